// File: hdl/rv_isa_pkg.sv
/* RV32I instruction set definitions */
package rv_isa_pkg;

    // data and address width
    localparam int xlen       = 32;
    localparam int reg_name_w = 5;
    localparam int op_w       = 6;

    // major opcodes in inst[6:0]
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    // funct7, base and alternate (sub, sra, srai)
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;

    // decoded operations
    typedef enum logic [op_w-1:0] {
        op_none,
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu,
        // register-immediate group, kept contiguous
        op_addi,
        op_slti,
        op_sltiu,
        op_xori,
        op_ori,
        op_andi,
        op_slli,
        op_srli,
        op_srai,
        // register-register group
        op_add,
        op_sub,
        op_sll,
        op_slt,
        op_sltu,
        op_xor,
        op_srl,
        op_sra,
        op_or,
        op_and
    } op_e;

endpackage

// File: hdl/rv_pipe_pkg.sv
/* Pipeline stage entries */
package rv_pipe_pkg;

    // decode to execute
    typedef struct packed {
        logic                                en;
        rv_isa_pkg::op_e                     op;
        logic [rv_isa_pkg::xlen-1:0]         pc;
        logic [rv_isa_pkg::xlen-1:0]         imm;
        logic [rv_isa_pkg::reg_name_w-1:0]   rs1;
        logic [rv_isa_pkg::reg_name_w-1:0]   rs2;
        logic [rv_isa_pkg::reg_name_w-1:0]   rd;
    } dec_entry_t;

    // execute to result
    typedef struct packed {
        logic                                en;
        // rd written and not x0
        logic                                wr;
        logic [rv_isa_pkg::reg_name_w-1:0]   rd;
        logic [rv_isa_pkg::xlen-1:0]         dt;
        // taken jump or branch
        logic                                jmp;
        logic [rv_isa_pkg::xlen-1:0]         j_pc;
    } res_entry_t;

endpackage

// File: hdl/rv_decoder.sv
/* Decode stage */
`timescale 1ns/1ns

module rv_decoder (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          clr,
    input  logic                          inst_en,
    input  logic [rv_isa_pkg::xlen-1:0]   inst,
    input  logic [rv_isa_pkg::xlen-1:0]   inst_pc,
    output rv_pipe_pkg::dec_entry_t       dec
);

    logic [6:0]                    opc;
    logic [2:0]                    f3;
    logic [6:0]                    f7;
    logic [rv_isa_pkg::xlen-1:0]   imm_i;
    logic [rv_isa_pkg::xlen-1:0]   imm_u;
    logic [rv_isa_pkg::xlen-1:0]   imm_j;
    logic [rv_isa_pkg::xlen-1:0]   imm_b;
    logic [rv_isa_pkg::xlen-1:0]   imm_d;
    rv_isa_pkg::op_e               op_d;

    assign opc = inst[6:0];
    assign f3  = inst[14:12];
    assign f7  = inst[31:25];

    // immediates, all sign extended from inst[31]
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        op_d  = rv_isa_pkg::op_none;
        imm_d = imm_i;
        case (opc)
            rv_isa_pkg::opc_lui: begin
                op_d  = rv_isa_pkg::op_lui;
                imm_d = imm_u;
            end
            rv_isa_pkg::opc_auipc: begin
                op_d  = rv_isa_pkg::op_auipc;
                imm_d = imm_u;
            end
            rv_isa_pkg::opc_jal: begin
                op_d  = rv_isa_pkg::op_jal;
                imm_d = imm_j;
            end
            rv_isa_pkg::opc_jalr: begin
                if (f3 == 3'b000) begin
                    op_d = rv_isa_pkg::op_jalr;
                end
            end
            rv_isa_pkg::opc_branch: begin
                imm_d = imm_b;
                case (f3)
                    3'b000:  op_d = rv_isa_pkg::op_beq;
                    3'b001:  op_d = rv_isa_pkg::op_bne;
                    3'b100:  op_d = rv_isa_pkg::op_blt;
                    3'b101:  op_d = rv_isa_pkg::op_bge;
                    3'b110:  op_d = rv_isa_pkg::op_bltu;
                    3'b111:  op_d = rv_isa_pkg::op_bgeu;
                    default: op_d = rv_isa_pkg::op_none;
                endcase
            end
            rv_isa_pkg::opc_op_imm: begin
                case (f3)
                    3'b000: op_d = rv_isa_pkg::op_addi;
                    3'b010: op_d = rv_isa_pkg::op_slti;
                    3'b011: op_d = rv_isa_pkg::op_sltiu;
                    3'b100: op_d = rv_isa_pkg::op_xori;
                    3'b110: op_d = rv_isa_pkg::op_ori;
                    3'b111: op_d = rv_isa_pkg::op_andi;
                    // shifts check funct7 too
                    3'b001: begin
                        if (f7 == rv_isa_pkg::f7_base) begin
                            op_d = rv_isa_pkg::op_slli;
                        end
                    end
                    default: begin
                        if (f7 == rv_isa_pkg::f7_base) begin
                            op_d = rv_isa_pkg::op_srli;
                        end else if (f7 == rv_isa_pkg::f7_alt) begin
                            op_d = rv_isa_pkg::op_srai;
                        end
                    end
                endcase
            end
            rv_isa_pkg::opc_op: begin
                case ({f7, f3})
                    {rv_isa_pkg::f7_base, 3'b000}: op_d = rv_isa_pkg::op_add;
                    {rv_isa_pkg::f7_alt,  3'b000}: op_d = rv_isa_pkg::op_sub;
                    {rv_isa_pkg::f7_base, 3'b001}: op_d = rv_isa_pkg::op_sll;
                    {rv_isa_pkg::f7_base, 3'b010}: op_d = rv_isa_pkg::op_slt;
                    {rv_isa_pkg::f7_base, 3'b011}: op_d = rv_isa_pkg::op_sltu;
                    {rv_isa_pkg::f7_base, 3'b100}: op_d = rv_isa_pkg::op_xor;
                    {rv_isa_pkg::f7_base, 3'b101}: op_d = rv_isa_pkg::op_srl;
                    {rv_isa_pkg::f7_alt,  3'b101}: op_d = rv_isa_pkg::op_sra;
                    {rv_isa_pkg::f7_base, 3'b110}: op_d = rv_isa_pkg::op_or;
                    {rv_isa_pkg::f7_base, 3'b111}: op_d = rv_isa_pkg::op_and;
                    default:                       op_d = rv_isa_pkg::op_none;
                endcase
            end
            default: op_d = rv_isa_pkg::op_none;
        endcase
    end

    // stage register, clr drops the word sampled at this edge
    always_ff @(posedge clk) begin
        if (rst) begin
            dec.en <= 1'b0;
        end else if (rdy) begin
            dec.en  <= inst_en & ~clr;
            dec.op  <= op_d;
            dec.pc  <= inst_pc;
            dec.imm <= imm_d;
            dec.rs1 <= inst[19:15];
            dec.rs2 <= inst[24:20];
            dec.rd  <= inst[11:7];
        end
    end

endmodule

// File: hdl/rv_execute.sv
/* Execute stage */
`timescale 1ns/1ns

module rv_execute #(
    parameter int num_regs = 32
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rdy,
    input  rv_pipe_pkg::dec_entry_t             dec,
    input  logic [rv_isa_pkg::xlen-1:0]         rs1_dt,
    input  logic [rv_isa_pkg::xlen-1:0]         rs2_dt,
    input  rv_pipe_pkg::res_entry_t             fwd,
    output logic [rv_isa_pkg::reg_name_w-1:0]   rs1,
    output logic [rv_isa_pkg::reg_name_w-1:0]   rs2,
    output logic                                clr,
    output rv_pipe_pkg::res_entry_t             res
);

    logic [rv_isa_pkg::xlen-1:0]   src1;
    logic [rv_isa_pkg::xlen-1:0]   src2;
    logic [rv_isa_pkg::xlen-1:0]   opb;
    logic [rv_isa_pkg::xlen-1:0]   alu;
    logic [rv_isa_pkg::xlen-1:0]   link;
    logic [rv_isa_pkg::xlen-1:0]   jalr_sum;
    logic [rv_isa_pkg::xlen-1:0]   target;
    logic [4:0]                    shamt;
    logic                          eq;
    logic                          lt_s;
    logic                          lt_u;
    logic                          taken;
    logic                          writes;
    rv_pipe_pkg::res_entry_t       res_d;

    assign rs1 = dec.rs1;
    assign rs2 = dec.rs2;

    // newest producer wins: own result register, then result stage, then file
    always_comb begin
        if (res.en && res.wr && res.rd == dec.rs1) begin
            src1 = res.dt;
        end else if (fwd.en && fwd.wr && fwd.rd == dec.rs1) begin
            src1 = fwd.dt;
        end else begin
            src1 = rs1_dt;
        end
        if (res.en && res.wr && res.rd == dec.rs2) begin
            src2 = res.dt;
        end else if (fwd.en && fwd.wr && fwd.rd == dec.rs2) begin
            src2 = fwd.dt;
        end else begin
            src2 = rs2_dt;
        end
    end

    assign opb   = (dec.op inside {[rv_isa_pkg::op_addi:rv_isa_pkg::op_srai]}) ? dec.imm : src2;
    assign shamt = opb[4:0];
    assign eq    = (src1 == opb);
    assign lt_s  = ($signed(src1) < $signed(opb));
    assign lt_u  = (src1 < opb);

    assign link     = dec.pc + 32'd4;
    assign jalr_sum = src1 + dec.imm;
    assign target   = (dec.op == rv_isa_pkg::op_jalr) ? {jalr_sum[rv_isa_pkg::xlen-1:1], 1'b0}
                                                      : dec.pc + dec.imm;

    always_comb begin
        alu    = '0;
        taken  = 1'b0;
        writes = 1'b1;
        case (dec.op)
            rv_isa_pkg::op_lui:   alu = dec.imm;
            rv_isa_pkg::op_auipc: alu = dec.pc + dec.imm;
            rv_isa_pkg::op_jal, rv_isa_pkg::op_jalr: begin
                alu   = link;
                taken = 1'b1;
            end
            rv_isa_pkg::op_beq: begin
                taken  = eq;
                writes = 1'b0;
            end
            rv_isa_pkg::op_bne: begin
                taken  = ~eq;
                writes = 1'b0;
            end
            rv_isa_pkg::op_blt: begin
                taken  = lt_s;
                writes = 1'b0;
            end
            rv_isa_pkg::op_bge: begin
                taken  = ~lt_s;
                writes = 1'b0;
            end
            rv_isa_pkg::op_bltu: begin
                taken  = lt_u;
                writes = 1'b0;
            end
            rv_isa_pkg::op_bgeu: begin
                taken  = ~lt_u;
                writes = 1'b0;
            end
            rv_isa_pkg::op_addi, rv_isa_pkg::op_add:   alu = src1 + opb;
            rv_isa_pkg::op_sub:                        alu = src1 - opb;
            rv_isa_pkg::op_slti, rv_isa_pkg::op_slt:   alu = {31'b0, lt_s};
            rv_isa_pkg::op_sltiu, rv_isa_pkg::op_sltu: alu = {31'b0, lt_u};
            rv_isa_pkg::op_xori, rv_isa_pkg::op_xor:   alu = src1 ^ opb;
            rv_isa_pkg::op_ori, rv_isa_pkg::op_or:     alu = src1 | opb;
            rv_isa_pkg::op_andi, rv_isa_pkg::op_and:   alu = src1 & opb;
            rv_isa_pkg::op_slli, rv_isa_pkg::op_sll:   alu = src1 << shamt;
            rv_isa_pkg::op_srli, rv_isa_pkg::op_srl:   alu = src1 >> shamt;
            rv_isa_pkg::op_srai, rv_isa_pkg::op_sra:   alu = $unsigned($signed(src1) >>> shamt);
            // op_none: no write, no redirect
            default: writes = 1'b0;
        endcase
    end

    // kills the next word entering decode
    assign clr = rdy & dec.en & taken;

    always_comb begin
        res_d.en   = dec.en;
        res_d.wr   = dec.en & writes & (dec.rd != '0) & (int'(dec.rd) < num_regs);
        res_d.rd   = dec.rd;
        res_d.dt   = alu;
        res_d.jmp  = dec.en & taken;
        res_d.j_pc = target;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res.en  <= 1'b0;
            res.wr  <= 1'b0;
            res.jmp <= 1'b0;
        end else if (rdy) begin
            res <= res_d;
        end
    end

endmodule

// File: hdl/rv_result.sv
/* Result stage and register file */
`timescale 1ns/1ns

module rv_result #(
    parameter int                          num_regs = 32,
    parameter logic [rv_isa_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rdy,
    input  rv_pipe_pkg::res_entry_t             res_in,
    input  logic [rv_isa_pkg::reg_name_w-1:0]   rs1,
    input  logic [rv_isa_pkg::reg_name_w-1:0]   rs2,
    output logic [rv_isa_pkg::xlen-1:0]         rs1_dt,
    output logic [rv_isa_pkg::xlen-1:0]         rs2_dt,
    output rv_pipe_pkg::res_entry_t             fwd,
    output logic                                wb_en,
    output logic [rv_isa_pkg::reg_name_w-1:0]   wb_rd,
    output logic [rv_isa_pkg::xlen-1:0]         wb_dt,
    output logic                                j_en,
    output logic [rv_isa_pkg::xlen-1:0]         j_pc
);

    localparam int idx_w = $clog2(num_regs);

    logic [rv_isa_pkg::xlen-1:0]   regs [num_regs];
    logic [rv_isa_pkg::xlen-1:0]   last_j_pc;
    rv_pipe_pkg::res_entry_t       held;

    // x0 and names beyond the file read zero
    function automatic logic [rv_isa_pkg::xlen-1:0] read_reg(
        input logic [rv_isa_pkg::reg_name_w-1:0] name
    );
        logic [rv_isa_pkg::xlen-1:0] val;
        val = '0;
        if (name != '0 && int'(name) < num_regs) begin
            val = regs[name[idx_w-1:0]];
        end
        return val;
    endfunction

    assign rs1_dt = read_reg(rs1);
    assign rs2_dt = read_reg(rs2);

    always_ff @(posedge clk) begin
        if (rst) begin
            held.en   <= 1'b0;
            held.wr   <= 1'b0;
            held.jmp  <= 1'b0;
            last_j_pc <= reset_pc;
        end else if (rdy) begin
            held <= res_in;
            if (res_in.en && res_in.jmp) begin
                last_j_pc <= res_in.j_pc;
            end
        end
    end

    // retire the held entry as it leaves
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (rdy && held.en && held.wr) begin
            regs[held.rd[idx_w-1:0]] <= held.dt;
        end
    end

    assign fwd   = held;
    assign wb_en = held.en & held.wr;
    assign wb_rd = held.rd;
    assign wb_dt = held.dt;
    assign j_en  = held.en & held.jmp;
    assign j_pc  = last_j_pc;

endmodule

// File: hdl/rv_exec_core.sv
/* RV32I integer execution slice */
`timescale 1ns/1ns

module rv_exec_core #(
    parameter int                          num_regs = 32,
    parameter logic [rv_isa_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                rdy,
    input  logic                                inst_en,
    input  logic [rv_isa_pkg::xlen-1:0]         inst,
    input  logic [rv_isa_pkg::xlen-1:0]         inst_pc,
    output logic                                wb_en,
    output logic [rv_isa_pkg::reg_name_w-1:0]   wb_rd,
    output logic [rv_isa_pkg::xlen-1:0]         wb_dt,
    output logic                                j_en,
    output logic [rv_isa_pkg::xlen-1:0]         j_pc
);

    rv_pipe_pkg::dec_entry_t              dec;
    rv_pipe_pkg::res_entry_t              res;
    rv_pipe_pkg::res_entry_t              fwd;
    logic                                 clr;
    logic [rv_isa_pkg::reg_name_w-1:0]    rs1;
    logic [rv_isa_pkg::reg_name_w-1:0]    rs2;
    logic [rv_isa_pkg::xlen-1:0]          rs1_dt;
    logic [rv_isa_pkg::xlen-1:0]          rs2_dt;

    rv_decoder i_rv_decoder (
        .clk     (clk),
        .rst     (rst),
        .rdy     (rdy),
        .clr     (clr),
        .inst_en (inst_en),
        .inst    (inst),
        .inst_pc (inst_pc),
        .dec     (dec)
    );

    rv_execute #(
        .num_regs (num_regs)
    ) i_rv_execute (
        .clk    (clk),
        .rst    (rst),
        .rdy    (rdy),
        .dec    (dec),
        .rs1_dt (rs1_dt),
        .rs2_dt (rs2_dt),
        .fwd    (fwd),
        .rs1    (rs1),
        .rs2    (rs2),
        .clr    (clr),
        .res    (res)
    );

    rv_result #(
        .num_regs (num_regs),
        .reset_pc (reset_pc)
    ) i_rv_result (
        .clk    (clk),
        .rst    (rst),
        .rdy    (rdy),
        .res_in (res),
        .rs1    (rs1),
        .rs2    (rs2),
        .rs1_dt (rs1_dt),
        .rs2_dt (rs2_dt),
        .fwd    (fwd),
        .wb_en  (wb_en),
        .wb_rd  (wb_rd),
        .wb_dt  (wb_dt),
        .j_en   (j_en),
        .j_pc   (j_pc)
    );

endmodule

// File: verif/rv_exec_core_tb.sv
/* Execution slice testbench */
`timescale 1ns/1ns

module rv_exec_core_tb;

    // what the outputs show after an edge
    typedef struct packed {
        logic        wr;
        logic [4:0]  rd;
        logic [31:0] dt;
        logic        jmp;
        logic [31:0] jpc;
    } out_t;

    typedef struct packed {
        logic [3:0]  test;
        logic        en;
        logic        rdy;
        logic [31:0] inst;
        logic [31:0] pc;
        out_t        exp;
    } row_t;

    logic        clk;
    logic        rst;
    logic        rdy;
    logic        inst_en;
    logic [31:0] inst;
    logic [31:0] inst_pc;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_dt;
    logic        j_en;
    logic [31:0] j_pc;

    row_t        tbl[$];
    logic [31:0] sh[32];
    out_t        x_ent;
    out_t        out_ent;
    logic        d_en;
    logic [31:0] d_inst;
    logic [31:0] d_pc;
    logic [31:0] last_jpc;
    logic [31:0] seed;
    logic [31:0] next_pc;
    logic [3:0]  cur_test;
    int          cycles = 0;
    int          limit;
    int          n_pass = 0;
    int          n_fail = 0;

    rv_exec_core i_rv_exec_core (
        .clk     (clk),
        .rst     (rst),
        .rdy     (rdy),
        .inst_en (inst_en),
        .inst    (inst),
        .inst_pc (inst_pc),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_dt   (wb_dt),
        .j_en    (j_en),
        .j_pc    (j_pc)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::opc_op};
    endfunction

    function automatic logic [31:0] itype(input logic [6:0] opc, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] utype(input logic [6:0] opc, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] jtype(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::opc_jal};
    endfunction

    function automatic logic [31:0] btype(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::opc_branch};
    endfunction

    // RV32I integer ops by funct3, alt selects sub and sra
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // architectural result of one instruction, updates the shadow file
    function automatic out_t eval_inst(input logic en, input logic [31:0] w,
                                       input logic [31:0] pc);
        out_t        o;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [2:0]  f3;
        o = '0;
        if (!en) begin
            return o;
        end
        a     = sh[w[19:15]];
        b     = sh[w[24:20]];
        imm   = {{20{w[31]}}, w[31:20]};
        f3    = w[14:12];
        o.rd  = w[11:7];
        o.wr  = 1'b1;
        case (w[6:0])
            rv_isa_pkg::opc_lui:   o.dt = {w[31:12], 12'b0};
            rv_isa_pkg::opc_auipc: o.dt = pc + {w[31:12], 12'b0};
            rv_isa_pkg::opc_jal: begin
                o.dt  = pc + 32'd4;
                o.jmp = 1'b1;
                o.jpc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            rv_isa_pkg::opc_jalr: begin
                o.dt  = pc + 32'd4;
                o.jmp = 1'b1;
                o.jpc = (a + imm) & ~32'd1;
            end
            rv_isa_pkg::opc_branch: begin
                o.wr  = 1'b0;
                o.jmp = f3[0] ^ (f3[2] ? (f3[1] ? a < b : $signed(a) < $signed(b)) : a == b);
                o.jpc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            rv_isa_pkg::opc_op_imm: o.dt = alu_ref(f3, f3 == 3'd5 && w[30], a, imm);
            rv_isa_pkg::opc_op: begin
                o.wr = (w[31:25] == rv_isa_pkg::f7_base)
                       || (w[31:25] == rv_isa_pkg::f7_alt && (f3 == 3'd0 || f3 == 3'd5));
                o.dt = alu_ref(f3, w[30], a, b);
            end
            default: o.wr = 1'b0;
        endcase
        o.wr = o.wr & (o.rd != 5'd0);
        if (o.wr) begin
            sh[o.rd] = o.dt;
        end
        return o;
    endfunction

    // one table row, the model steps only on cycles with rdy high
    task automatic add_row(input logic en, input logic rdy_v, input logic [31:0] w);
        row_t r;
        r.test = cur_test;
        r.en   = en;
        r.rdy  = rdy_v;
        r.inst = w;
        r.pc   = next_pc;
        if (rdy_v) begin
            out_ent = x_ent;
            if (out_ent.jmp) begin
                last_jpc = out_ent.jpc;
            end
            x_ent  = eval_inst(d_en, d_inst, d_pc);
            // a taken transfer kills the word sampled at the same edge
            d_en   = en & ~x_ent.jmp;
            d_inst = w;
            d_pc   = next_pc;
            next_pc = en ? next_pc + 32'd4 : next_pc;
        end
        r.exp     = out_ent;
        r.exp.jpc = last_jpc;
        tbl.push_back(r);
    endtask

    task automatic issue(input logic [31:0] w);
        add_row(1'b1, 1'b1, w);
    endtask

    task automatic idle(input int n);
        for (int k = 0; k < n; k++) begin
            add_row(1'b0, 1'b1, 32'd0);
        end
    endtask

    // shadow of a jump, first one is killed when taken
    task automatic issue_pair();
        issue(itype(rv_isa_pkg::opc_op_imm, 3'd0, 5'd28, 5'd28, 12'd1));
        issue(itype(rv_isa_pkg::opc_op_imm, 3'd0, 5'd29, 5'd28, 12'd3));
    endtask

    task automatic build_table();
        logic [31:0] v;
        logic [31:0] w;
        for (int k = 0; k < 32; k++) begin
            sh[k] = '0;
        end
        cur_test = 4'd1;
        issue(rtype(rv_isa_pkg::f7_base, 3'd0, 5'd5, 5'd0, 5'd0));
        idle(2);
        // random values in x1..x8, then every ALU op
        cur_test = 4'd2;
        for (int k = 1; k <= 8; k++) begin
            v = next_rand();
            issue(utype(rv_isa_pkg::opc_lui, 5'(k), v[31:12]));
            issue(itype(rv_isa_pkg::opc_op_imm, 3'd0, 5'(k), 5'(k), v[11:0]));
        end
        issue(utype(rv_isa_pkg::opc_auipc, 5'd30, v[19:0]));
        for (int f = 0; f < 8; f++) begin
            v = next_rand();
            issue(itype(rv_isa_pkg::opc_op_imm, 3'(f), 5'(9 + f), {2'b0, v[14:12]} + 5'd1,
                        (f == 1 || f == 5) ? {7'b0, v[4:0]} : v[11:0]));
        end
        issue(itype(rv_isa_pkg::opc_op_imm, 3'd5, 5'd17, 5'd8, {rv_isa_pkg::f7_alt, v[4:0]}));
        for (int f = 0; f < 10; f++) begin
            v = next_rand();
            issue(rtype(f < 8 ? rv_isa_pkg::f7_base : rv_isa_pkg::f7_alt,
                        f < 8 ? 3'(f) : (f == 8 ? 3'd0 : 3'd5),
                        5'(18 + f), {1'b0, v[3:0]} + 5'd1, {1'b0, v[7:4]} + 5'd1));
        end
        issue(itype(rv_isa_pkg::opc_op_imm, 3'd0, 5'd0, 5'd1, 12'd5));
        idle(2);
        // dependent chains at spacing 1, 2 and 3
        cur_test = 4'd3;
        issue(itype(rv_isa_pkg::opc_op_imm, 3'd0, 5'd20, 5'd1, 12'h7f3));
        issue(rtype(rv_isa_pkg::f7_base, 3'd0, 5'd21, 5'd20, 5'd2));
        issue(rtype(rv_isa_pkg::f7_alt, 3'd0, 5'd22, 5'd20, 5'd21));
        idle(1);
        issue(rtype(rv_isa_pkg::f7_base, 3'd4, 5'd23, 5'd22, 5'd21));
        idle(2);
        issue(rtype(rv_isa_pkg::f7_base, 3'd7, 5'd24, 5'd23, 5'd20));
        idle(2);
        // each branch on equal and both unequal orders
        cur_test = 4'd4;
        for (int f = 0; f < 8; f++) begin
            for (int p = 0; p < 3 && f != 2 && f != 3; p++) begin
                v = next_rand();
                issue(btype(3'(f), p == 2 ? 5'd2 : 5'd1, p == 1 ? 5'd2 : 5'd1, {v[12:1], 1'b0}));
                issue_pair();
            end
        end
        v = next_rand();
        issue(jtype(5'd26, {v[20:1], 1'b0}));
        issue_pair();
        issue(itype(rv_isa_pkg::opc_jalr, 3'd0, 5'd27, 5'd26, v[31:20]));
        issue_pair();
        idle(2);
        // rdy low for 4 cycles mid stream
        cur_test = 4'd5;
        issue(itype(rv_isa_pkg::opc_op_imm, 3'd0, 5'd10, 5'd1, 12'd11));
        issue(rtype(rv_isa_pkg::f7_base, 3'd0, 5'd11, 5'd10, 5'd2));
        w = rtype(rv_isa_pkg::f7_alt, 3'd0, 5'd12, 5'd11, 5'd10);
        for (int k = 0; k < 4; k++) begin
            add_row(1'b1, 1'b0, w);
        end
        issue(w);
        issue(rtype(rv_isa_pkg::f7_base, 3'd4, 5'd13, 5'd12, 5'd11));
        idle(2);
        // load opcode, MUL encoding and a word with inst_en low
        cur_test = 4'd6;
        issue(itype(7'b0000011, 3'd2, 5'd5, 5'd1, 12'd0));
        issue(rtype(7'b0000001, 3'd0, 5'd6, 5'd1, 5'd2));
        add_row(1'b0, 1'b1, rtype(rv_isa_pkg::f7_base, 3'd0, 5'd7, 5'd1, 5'd2));
        idle(2);
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp === act) begin
            n_pass++;
        end else begin
            n_fail++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: simulation did not finish within %0d cycles", limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        int t_fail;
        clk      = 1'b0;
        rst      = 1'b1;
        rdy      = 1'b1;
        inst_en  = 1'b0;
        inst     = '0;
        inst_pc  = '0;
        seed     = 32'h04e2_92db;
        next_pc  = '0;
        last_jpc = '0;
        d_en     = 1'b0;
        d_inst   = '0;
        d_pc     = '0;
        x_ent    = '0;
        out_ent  = '0;
        build_table();
        limit = tbl.size() + 8 + 20;
        repeat (8) @(posedge clk);
        #2;
        rst    = 1'b0;
        t_fail = 0;
        for (int i = 0; i < tbl.size(); i++) begin
            rdy     = tbl[i].rdy;
            inst_en = tbl[i].en;
            inst    = tbl[i].inst;
            inst_pc = tbl[i].pc;
            @(posedge clk);
            #2;
            check("wb_en", 32'(tbl[i].exp.wr), 32'(wb_en));
            if (tbl[i].exp.wr) begin
                check("wb_rd", 32'(tbl[i].exp.rd), 32'(wb_rd));
                check("wb_dt", tbl[i].exp.dt, wb_dt);
            end
            check("j_en", 32'(tbl[i].exp.jmp), 32'(j_en));
            check("j_pc", tbl[i].exp.jpc, j_pc);
            if (i == tbl.size() - 1 || tbl[i + 1].test != tbl[i].test) begin
                $display("test %0d done, %0d mismatches", tbl[i].test, n_fail - t_fail);
                t_fail = n_fail;
            end
        end
        $display("checks passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: compile.f
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rv_decoder.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_exec_core.sv
verif/rv_exec_core_tb.sv

// File: Makefile
sim:
	verilator --binary --timing -j 0 --top-module rv_exec_core_tb -f compile.f
	@out="$$(./obj_dir/Vrv_exec_core_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

.PHONY: sim clean
